// File: hw/proc_pkg.sv
/* widths, instruction encodings and control enums shared by the core
   and its testbench, always referenced by scoped name */

package proc_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;

  // manager csr numbers
  localparam csr_addr_t csr_proc2mngr = 12'h7c0;
  localparam csr_addr_t csr_mngr2proc = 12'hfc0;

  // ------------------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------------------

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_system = 7'b1110011;

  // funct3 for op and op-imm
  localparam logic [2:0] f3_add_sub = 3'd0;
  localparam logic [2:0] f3_sll     = 3'd1;
  localparam logic [2:0] f3_slt     = 3'd2;
  localparam logic [2:0] f3_sltu    = 3'd3;
  localparam logic [2:0] f3_xor     = 3'd4;
  localparam logic [2:0] f3_srl_sra = 3'd5;
  localparam logic [2:0] f3_or      = 3'd6;
  localparam logic [2:0] f3_and     = 3'd7;

  // funct3 for branch and system
  localparam logic [2:0] f3_beq   = 3'd0;
  localparam logic [2:0] f3_bne   = 3'd1;
  localparam logic [2:0] f3_csrrw = 3'd1;
  localparam logic [2:0] f3_csrrs = 3'd2;

  // instruction bit that picks sub over add, sra over srl
  localparam int unsigned f7_alt_bit = 30;

  // ------------------------------------------------------------------------
  // control enums
  // ------------------------------------------------------------------------

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
    alu_sltu, alu_sra, alu_srl, alu_sll, alu_cp0, alu_cp1
  } alu_fn_e;

  typedef enum logic [1:0] {op2_rf, op2_imm, op2_mngr} op2_sel_e;
  typedef enum logic       {imm_i, imm_b} imm_type_e;
  typedef enum logic [1:0] {br_none, br_bne, br_beq} br_type_e;
  typedef enum logic       {pc_plus4, pc_branch} pc_sel_e;

endpackage

// File: hw/proc_ctrl.sv
`timescale 1ns/1ps
/* control unit of the five-stage core: valid bits, decode table,
   interlocks and branch squash, plus the control pipeline to W */

module proc_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  // instruction memory strobes
  output logic                  imem_req_val,
  input  logic                  imem_req_rdy,
  input  logic                  imem_resp_val,
  output logic                  imem_resp_rdy,
  output logic                  imem_resp_drop,
  // manager strobes
  input  logic                  mngr2proc_val,
  output logic                  mngr2proc_rdy,
  output logic                  proc2mngr_val,
  input  logic                  proc2mngr_rdy,
  output logic                  commit_inst,
  // to the datapath
  output logic                  reg_en_f,
  output logic                  reg_en_d,
  output logic                  reg_en_x,
  output logic                  reg_en_m,
  output logic                  reg_en_w,
  output proc_pkg::pc_sel_e     pc_sel_f,
  output proc_pkg::imm_type_e   imm_type_d,
  output proc_pkg::op2_sel_e    op2_sel_d,
  output proc_pkg::alu_fn_e     alu_fn_x,
  output proc_pkg::reg_addr_t   rf_waddr_w,
  output logic                  rf_wen_w,
  // from the datapath
  input  proc_pkg::word_t       inst_d,
  input  logic                  br_cond_eq_x
);

  logic val_f, val_d, val_x, val_m, val_w;
  // ostall_* originates in a stage, stall_* also counts the stages ahead
  logic ostall_f, ostall_d, ostall_x, ostall_w, ostall_hazard_d;
  logic stall_f, stall_d, stall_x, stall_m, stall_w;
  logic osquash_x, squash_f, squash_d;
  logic next_val_f, next_val_d, next_val_x, next_val_m;

  // D decode results
  proc_pkg::br_type_e br_type_d;
  proc_pkg::alu_fn_e  alu_fn_d;
  logic rs1_en_d, rs2_en_d, rf_wen_d, csrr_d, csrw_d, p2m_d, m2p_d;

  // control pipeline X..W
  proc_pkg::br_type_e  br_type_x;
  proc_pkg::reg_addr_t rf_waddr_x, rf_waddr_m;
  logic rf_wen_x, rf_wen_m, rf_wen_pend_w;
  logic p2m_x, p2m_m, p2m_w;
  logic pc_redirect_x;

  // a source read in D that a valid older instruction still has to write
  function automatic logic raw(input logic en, input proc_pkg::reg_addr_t src,
                               input logic val, input logic wen,
                               input proc_pkg::reg_addr_t dst);
    return en && val && wen && (src == dst) && (dst != '0);
  endfunction

  // --------------------------------------------------------------------------
  // F stage
  // --------------------------------------------------------------------------

  assign reg_en_f = !stall_f || squash_f;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
    end else if (reg_en_f) begin
      val_f <= 1'b1;
    end
  end

  assign pc_sel_f = pc_redirect_x ? proc_pkg::pc_branch : proc_pkg::pc_plus4;
  assign ostall_f = val_f && !imem_resp_val;
  // a refused request holds the pc, even with F empty
  assign stall_f  = (val_f && (ostall_f || ostall_d || ostall_x || ostall_w))
                    || !imem_req_rdy;
  assign squash_f = val_f && osquash_x;

  // squashed fetch has its response thrown away by the memory
  assign imem_resp_drop = squash_f;
  assign imem_req_val   = reg_en_f && !reset;
  assign imem_resp_rdy  = !stall_f && !squash_f;
  assign next_val_f     = val_f && !stall_f && !squash_f;

  // --------------------------------------------------------------------------
  // D stage
  // --------------------------------------------------------------------------

  assign reg_en_d = !stall_d || squash_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (reg_en_d) begin
      val_d <= next_val_f;
    end
  end

  // decode table
  always_comb begin
    br_type_d  = proc_pkg::br_none;
    imm_type_d = proc_pkg::imm_i;
    op2_sel_d  = proc_pkg::op2_rf;
    alu_fn_d   = proc_pkg::alu_add;
    rs1_en_d   = 1'b0;
    rs2_en_d   = 1'b0;
    rf_wen_d   = 1'b0;
    csrr_d     = 1'b0;
    csrw_d     = 1'b0;
    case (inst_d[6:0])
      proc_pkg::opc_op: begin
        rs1_en_d = 1'b1;
        rs2_en_d = 1'b1;
        rf_wen_d = 1'b1;
        case (inst_d[14:12])
          proc_pkg::f3_add_sub: alu_fn_d = inst_d[proc_pkg::f7_alt_bit] ?
                                           proc_pkg::alu_sub : proc_pkg::alu_add;
          proc_pkg::f3_sll:     alu_fn_d = proc_pkg::alu_sll;
          proc_pkg::f3_slt:     alu_fn_d = proc_pkg::alu_slt;
          proc_pkg::f3_sltu:    alu_fn_d = proc_pkg::alu_sltu;
          proc_pkg::f3_xor:     alu_fn_d = proc_pkg::alu_xor;
          proc_pkg::f3_srl_sra: alu_fn_d = inst_d[proc_pkg::f7_alt_bit] ?
                                           proc_pkg::alu_sra : proc_pkg::alu_srl;
          proc_pkg::f3_or:      alu_fn_d = proc_pkg::alu_or;
          default:              alu_fn_d = proc_pkg::alu_and;
        endcase
      end
      // addi only
      proc_pkg::opc_op_imm: begin
        if (inst_d[14:12] == proc_pkg::f3_add_sub) begin
          rs1_en_d  = 1'b1;
          rf_wen_d  = 1'b1;
          op2_sel_d = proc_pkg::op2_imm;
        end
      end
      proc_pkg::opc_branch: begin
        imm_type_d = proc_pkg::imm_b;
        rs1_en_d   = 1'b1;
        rs2_en_d   = 1'b1;
        if (inst_d[14:12] == proc_pkg::f3_beq) begin
          br_type_d = proc_pkg::br_beq;
        end else if (inst_d[14:12] == proc_pkg::f3_bne) begin
          br_type_d = proc_pkg::br_bne;
        end
      end
      // csrr passes mngr2proc data, csrw passes rs1
      proc_pkg::opc_system: begin
        if (inst_d[14:12] == proc_pkg::f3_csrrs) begin
          csrr_d    = 1'b1;
          rf_wen_d  = 1'b1;
          op2_sel_d = proc_pkg::op2_mngr;
          alu_fn_d  = proc_pkg::alu_cp1;
        end else if (inst_d[14:12] == proc_pkg::f3_csrrw) begin
          csrw_d   = 1'b1;
          rs1_en_d = 1'b1;
          alu_fn_d = proc_pkg::alu_cp0;
        end
      end
      default: ;
    endcase
  end

  assign p2m_d = csrw_d && (proc_pkg::csr_addr_t'(inst_d[31:20]) == proc_pkg::csr_proc2mngr);
  assign m2p_d = csrr_d && (proc_pkg::csr_addr_t'(inst_d[31:20]) == proc_pkg::csr_mngr2proc);

  // no bypass paths, so any pending writer in X, M or W holds D
  assign ostall_hazard_d =
      raw(rs1_en_d, inst_d[19:15], val_x, rf_wen_x, rf_waddr_x) ||
      raw(rs1_en_d, inst_d[19:15], val_m, rf_wen_m, rf_waddr_m) ||
      raw(rs1_en_d, inst_d[19:15], val_w, rf_wen_pend_w, rf_waddr_w) ||
      raw(rs2_en_d, inst_d[24:20], val_x, rf_wen_x, rf_waddr_x) ||
      raw(rs2_en_d, inst_d[24:20], val_m, rf_wen_m, rf_waddr_m) ||
      raw(rs2_en_d, inst_d[24:20], val_w, rf_wen_pend_w, rf_waddr_w);

  assign ostall_d = val_d && ((m2p_d && !mngr2proc_val) || ostall_hazard_d);
  assign stall_d  = val_d && (ostall_d || ostall_x || ostall_w);
  assign squash_d = val_d && osquash_x;

  // take a value only in the cycle csrr leaves D
  assign mngr2proc_rdy = val_d && m2p_d && !ostall_hazard_d && !ostall_x
                         && !ostall_w && !squash_d;
  assign next_val_d    = val_d && !stall_d && !squash_d;

  // --------------------------------------------------------------------------
  // X stage
  // --------------------------------------------------------------------------

  assign reg_en_x = !stall_x;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
    end else if (reg_en_x) begin
      val_x <= next_val_d;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_x) begin
      br_type_x  <= br_type_d;
      alu_fn_x   <= alu_fn_d;
      rf_wen_x   <= rf_wen_d;
      rf_waddr_x <= inst_d[11:7];
      p2m_x      <= p2m_d;
    end
  end

  assign pc_redirect_x = val_x &&
      ((br_type_x == proc_pkg::br_bne && !br_cond_eq_x) ||
       (br_type_x == proc_pkg::br_beq &&  br_cond_eq_x));

  // taken branch waits until memory can take the target request
  assign ostall_x   = pc_redirect_x && !imem_req_rdy;
  assign stall_x    = val_x && (ostall_x || ostall_w);
  assign osquash_x  = pc_redirect_x && !stall_x;
  assign next_val_x = val_x && !stall_x;

  // --------------------------------------------------------------------------
  // M and W stages
  // --------------------------------------------------------------------------

  assign reg_en_m = !stall_m;
  assign stall_m  = val_m && ostall_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_m <= 1'b0;
    end else if (reg_en_m) begin
      val_m <= next_val_x;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_m) begin
      rf_wen_m   <= rf_wen_x;
      rf_waddr_m <= rf_waddr_x;
      p2m_m      <= p2m_x;
    end
  end

  assign next_val_m = val_m && !stall_m;
  assign reg_en_w   = !stall_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_w <= 1'b0;
    end else if (reg_en_w) begin
      val_w <= next_val_m;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_w) begin
      rf_wen_pend_w <= rf_wen_m;
      rf_waddr_w    <= rf_waddr_m;
      p2m_w         <= p2m_m;
    end
  end

  // proc2mngr back-pressure is the only W stall
  assign ostall_w = val_w && p2m_w && !proc2mngr_rdy;
  assign stall_w  = ostall_w;

  assign rf_wen_w      = val_w && rf_wen_pend_w;
  assign proc2mngr_val = val_w && p2m_w;
  assign commit_inst   = val_w && !stall_w;

endmodule

// File: hw/proc_fetch.sv
`timescale 1ns/1ps
/* fetch datapath: pc register, next-pc mux and request address;
   the pc that was fetched moves on to D with the F register enable */

module proc_fetch #(
  parameter proc_pkg::word_t reset_pc = 32'h0000_0200
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              reg_en_f,
  input  proc_pkg::pc_sel_e pc_sel_f,
  input  proc_pkg::word_t   br_target_x,
  output proc_pkg::word_t   imem_req_addr,
  output proc_pkg::word_t   pc_d
);

  proc_pkg::word_t pc_f;
  proc_pkg::word_t pc_next_f;

  // request goes out for the next pc, before the F register
  assign pc_next_f = (pc_sel_f == proc_pkg::pc_branch) ? br_target_x : pc_f + 32'd4;
  assign imem_req_addr = pc_next_f;

  // one word below reset_pc so the first request hits reset_pc
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= reset_pc - 32'd4;
    end else if (reg_en_f) begin
      pc_f <= pc_next_f;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_f) begin
      pc_d <= pc_f;
    end
  end

endmodule

// File: hw/proc_regfile.sv
`timescale 1ns/1ps
/* 32 x 32 register file, two combinational reads and one
   write on the clock edge; x0 reads as zero */

module proc_regfile (
  input  logic                clk,
  input  proc_pkg::reg_addr_t raddr0,
  output proc_pkg::word_t     rdata0,
  input  proc_pkg::reg_addr_t raddr1,
  output proc_pkg::word_t     rdata1,
  input  logic                wen,
  input  proc_pkg::reg_addr_t waddr,
  input  proc_pkg::word_t     wdata
);

  proc_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // write in W lands after the D read, the control interlock covers that
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// File: hw/proc_decode_dpath.sv
`timescale 1ns/1ps
/* decode datapath: instruction register, immediates, operand 2
   selection and the branch target add */

module proc_decode_dpath (
  input  logic                clk,
  input  logic                reg_en_d,
  input  proc_pkg::word_t     imem_resp_data,
  input  proc_pkg::word_t     pc_d,
  input  proc_pkg::imm_type_e imm_type_d,
  input  proc_pkg::op2_sel_e  op2_sel_d,
  input  proc_pkg::word_t     mngr2proc_data,
  input  proc_pkg::word_t     rf_rdata0,
  input  proc_pkg::word_t     rf_rdata1,
  output proc_pkg::word_t     inst_d,
  output proc_pkg::reg_addr_t rs1_addr_d,
  output proc_pkg::reg_addr_t rs2_addr_d,
  output proc_pkg::word_t     op1_d,
  output proc_pkg::word_t     op2_d,
  output proc_pkg::word_t     rs2_data_d,
  output proc_pkg::word_t     br_target_d
);

  proc_pkg::word_t imm_d;

  always_ff @(posedge clk) begin
    if (reg_en_d) begin
      inst_d <= imem_resp_data;
    end
  end

  assign rs1_addr_d = inst_d[19:15];
  assign rs2_addr_d = inst_d[24:20];

  // sign-extended i or b immediate
  assign imm_d = (imm_type_d == proc_pkg::imm_b) ?
                 {{20{inst_d[31]}}, inst_d[7], inst_d[30:25], inst_d[11:8], 1'b0} :
                 {{20{inst_d[31]}}, inst_d[31:20]};

  always_comb begin
    case (op2_sel_d)
      proc_pkg::op2_imm:  op2_d = imm_d;
      proc_pkg::op2_mngr: op2_d = mngr2proc_data;
      default:            op2_d = rf_rdata1;
    endcase
  end

  assign op1_d       = rf_rdata0;
  assign rs2_data_d  = rf_rdata1;
  assign br_target_d = pc_d + imm_d;

endmodule

// File: hw/proc_exec_dpath.sv
`timescale 1ns/1ps
/* execute datapath: X operand registers, the ALU and the
   equality flag that resolves bne/beq */

module proc_exec_dpath (
  input  logic              clk,
  input  logic              reg_en_x,
  input  proc_pkg::word_t   op1_d,
  input  proc_pkg::word_t   op2_d,
  input  proc_pkg::word_t   rs2_data_d,
  input  proc_pkg::word_t   br_target_d,
  input  proc_pkg::alu_fn_e alu_fn_x,
  output proc_pkg::word_t   br_target_x,
  output logic              br_cond_eq_x,
  output proc_pkg::word_t   result_x
);

  proc_pkg::word_t op1_x;
  proc_pkg::word_t op2_x;
  proc_pkg::word_t rs2_data_x;
  logic [4:0]      shamt_x;

  always_ff @(posedge clk) begin
    if (reg_en_x) begin
      op1_x       <= op1_d;
      op2_x       <= op2_d;
      rs2_data_x  <= rs2_data_d;
      br_target_x <= br_target_d;
    end
  end

  // branch compares rs1 with rs2 itself, op2 may hold the immediate
  assign br_cond_eq_x = (op1_x == rs2_data_x);
  assign shamt_x      = op2_x[4:0];

  always_comb begin
    case (alu_fn_x)
      proc_pkg::alu_add:  result_x = op1_x + op2_x;
      proc_pkg::alu_sub:  result_x = op1_x - op2_x;
      proc_pkg::alu_and:  result_x = op1_x & op2_x;
      proc_pkg::alu_or:   result_x = op1_x | op2_x;
      proc_pkg::alu_xor:  result_x = op1_x ^ op2_x;
      proc_pkg::alu_slt:  result_x = {31'd0, $signed(op1_x) < $signed(op2_x)};
      proc_pkg::alu_sltu: result_x = {31'd0, op1_x < op2_x};
      proc_pkg::alu_sra:  result_x = $unsigned($signed(op1_x) >>> shamt_x);
      proc_pkg::alu_srl:  result_x = op1_x >> shamt_x;
      proc_pkg::alu_sll:  result_x = op1_x << shamt_x;
      // copies for csrw and csrr
      proc_pkg::alu_cp0:  result_x = op1_x;
      proc_pkg::alu_cp1:  result_x = op2_x;
      default:            result_x = '0;
    endcase
  end

endmodule

// File: hw/proc_retire_dpath.sv
`timescale 1ns/1ps
/* M and W result registers; the W value feeds both the
   register file write and proc2mngr data */

module proc_retire_dpath (
  input  logic            clk,
  input  logic            reg_en_m,
  input  logic            reg_en_w,
  input  proc_pkg::word_t result_x,
  output proc_pkg::word_t result_w
);

  proc_pkg::word_t result_m;

  // M has no memory access, it only delays the result
  always_ff @(posedge clk) begin
    if (reg_en_m) begin
      result_m <= result_x;
    end
  end

  // held while W stalls on proc2mngr
  always_ff @(posedge clk) begin
    if (reg_en_w) begin
      result_w <= result_m;
    end
  end

endmodule

// File: hw/proc_top.sv
`timescale 1ns/1ps
/* top of the five-stage core: control unit, fetch, decode, execute
   and retire datapaths, and the register file; reset_pc goes to fetch */

module proc_top #(
  parameter proc_pkg::word_t reset_pc = 32'h0000_0200
) (
  input  logic            clk,
  input  logic            reset,
  // instruction memory
  output logic            imem_req_val,
  input  logic            imem_req_rdy,
  output proc_pkg::word_t imem_req_addr,
  input  logic            imem_resp_val,
  output logic            imem_resp_rdy,
  output logic            imem_resp_drop,
  input  proc_pkg::word_t imem_resp_data,
  // manager
  input  logic            mngr2proc_val,
  output logic            mngr2proc_rdy,
  input  proc_pkg::word_t mngr2proc_data,
  output logic            proc2mngr_val,
  input  logic            proc2mngr_rdy,
  output proc_pkg::word_t proc2mngr_data,
  output logic            commit_inst
);

  // ------------------------------------------------------------------------
  // control to datapath
  // ------------------------------------------------------------------------

  logic reg_en_f, reg_en_d, reg_en_x, reg_en_m, reg_en_w;
  logic rf_wen_w;
  proc_pkg::pc_sel_e   pc_sel_f;
  proc_pkg::imm_type_e imm_type_d;
  proc_pkg::op2_sel_e  op2_sel_d;
  proc_pkg::alu_fn_e   alu_fn_x;
  proc_pkg::reg_addr_t rf_waddr_w;

  // ------------------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------------------

  proc_pkg::word_t     pc_d, inst_d, op1_d, op2_d, rs2_data_d, br_target_d;
  proc_pkg::word_t     rf_rdata0, rf_rdata1;
  proc_pkg::reg_addr_t rs1_addr_d, rs2_addr_d;
  proc_pkg::word_t     br_target_x, result_x, result_w;
  logic                br_cond_eq_x;

  proc_ctrl i_ctrl (.*);

  proc_fetch #(
    .reset_pc(reset_pc)
  ) i_fetch (.*);

  proc_decode_dpath i_decode (.*);

  proc_regfile i_regfile (
    .clk    (clk),
    .raddr0 (rs1_addr_d),
    .rdata0 (rf_rdata0),
    .raddr1 (rs2_addr_d),
    .rdata1 (rf_rdata1),
    .wen    (rf_wen_w),
    .waddr  (rf_waddr_w),
    .wdata  (result_w)
  );

  proc_exec_dpath i_exec (.*);

  proc_retire_dpath i_retire (.*);

  // csrw results leave from W
  assign proc2mngr_data = result_w;

endmodule

// File: dv/proc_tb_model.svh
/* program image for the core testbench, and an instruction level model
   that runs it on the mngr2proc values and queues the proc2mngr values */

// image, one word per entry from reset_pc upwards
proc_pkg::word_t prog [$];
proc_pkg::word_t exp_vals [$];
string           exp_tags [$];
int              model_count;
int              mngr_used;
proc_pkg::word_t alu_pc;
proc_pkg::word_t br_pc;

// --------------------------------------------------------------------------
// encoders
// --------------------------------------------------------------------------

function automatic proc_pkg::word_t enc_r(logic [6:0] f7, logic [4:0] rd, logic [4:0] rs1,
                                          logic [4:0] rs2, logic [2:0] f3);
  return {f7, rs2, rs1, f3, rd, proc_pkg::opc_op};
endfunction

function automatic proc_pkg::word_t enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
  return {imm, rs1, proc_pkg::f3_add_sub, rd, proc_pkg::opc_op_imm};
endfunction

function automatic proc_pkg::word_t enc_branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                               logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], proc_pkg::opc_branch};
endfunction

// csrrs rd, mngr2proc, x0
function automatic proc_pkg::word_t enc_csrr(logic [4:0] rd);
  return {proc_pkg::csr_mngr2proc, 5'd0, proc_pkg::f3_csrrs, rd, proc_pkg::opc_system};
endfunction

// csrrw x0, proc2mngr, rs1
function automatic proc_pkg::word_t enc_csrw(logic [4:0] rs1);
  return {proc_pkg::csr_proc2mngr, rs1, proc_pkg::f3_csrrw, 5'd0, proc_pkg::opc_system};
endfunction

function automatic void emit(proc_pkg::word_t w);
  prog.push_back(w);
endfunction

function automatic proc_pkg::word_t here();
  return reset_pc + 32'(4 * prog.size());
endfunction

// outside the image: opcode 7'h7f, which the core does not decode
function automatic proc_pkg::word_t fetch_word(proc_pkg::word_t addr);
  if (addr >= reset_pc && ((addr - reset_pc) >> 2) < prog.size() && addr[1:0] == 2'b00) begin
    return prog[(addr - reset_pc) >> 2];
  end
  return (addr * 32'h9e37_79b9) | 32'h0000_007f;
endfunction

function automatic string section_of(proc_pkg::word_t pc);
  if (pc < alu_pc) begin
    return "echo";
  end
  return (pc < br_pc) ? "alu" : "branch";
endfunction

// --------------------------------------------------------------------------
// program
// --------------------------------------------------------------------------

task automatic build_program();
  proc_pkg::word_t loop_pc;
  repeat (6) begin
    emit(enc_csrr(5'd1));
    emit(enc_csrw(5'd1));
  end
  // three passes of a dependent alu chain, closed by bne
  alu_pc = here();
  emit(enc_addi(5'd20, 5'd0, 12'd3));
  loop_pc = here();
  emit(enc_csrr(5'd2));
  emit(enc_csrr(5'd3));
  emit(enc_r(7'h00, 5'd4, 5'd2, 5'd3, 3'd0));
  emit(enc_csrw(5'd4));
  emit(enc_r(7'h20, 5'd5, 5'd4, 5'd2, 3'd0));
  emit(enc_csrw(5'd5));
  emit(enc_r(7'h00, 5'd6, 5'd5, 5'd3, 3'd7));
  emit(enc_r(7'h00, 5'd7, 5'd6, 5'd2, 3'd6));
  emit(enc_r(7'h00, 5'd8, 5'd7, 5'd3, 3'd4));
  emit(enc_csrw(5'd8));
  emit(enc_r(7'h00, 5'd9, 5'd8, 5'd2, 3'd2));
  emit(enc_csrw(5'd9));
  emit(enc_r(7'h00, 5'd10, 5'd8, 5'd3, 3'd3));
  emit(enc_csrw(5'd10));
  emit(enc_r(7'h00, 5'd11, 5'd8, 5'd3, 3'd1));
  emit(enc_r(7'h00, 5'd12, 5'd11, 5'd2, 3'd5));
  emit(enc_csrw(5'd12));
  emit(enc_r(7'h20, 5'd13, 5'd8, 5'd3, 3'd5));
  emit(enc_addi(5'd14, 5'd13, 12'hffb));
  emit(enc_addi(5'd15, 5'd14, 12'h7ff));
  emit(enc_csrw(5'd15));
  emit(enc_addi(5'd20, 5'd20, 12'hfff));
  emit(enc_branch(proc_pkg::f3_bne, 5'd20, 5'd0, 13'(loop_pc - here())));
  // beq and bne both ways, the skipped csrw is a wrong-path write
  br_pc = here();
  emit(enc_csrr(5'd2));
  emit(enc_csrr(5'd3));
  emit(enc_branch(proc_pkg::f3_beq, 5'd2, 5'd2, 13'd8));
  emit(enc_csrw(5'd3));
  emit(enc_csrw(5'd2));
  emit(enc_branch(proc_pkg::f3_beq, 5'd2, 5'd3, 13'd8));
  emit(enc_csrw(5'd3));
  emit(enc_branch(proc_pkg::f3_bne, 5'd2, 5'd2, 13'd8));
  emit(enc_csrw(5'd2));
  emit(enc_branch(proc_pkg::f3_bne, 5'd2, 5'd3, 13'd8));
  emit(enc_csrw(5'd3));
  // countdown, beq exits and a backward beq repeats
  emit(enc_addi(5'd21, 5'd0, 12'd2));
  loop_pc = here();
  emit(enc_csrw(5'd21));
  emit(enc_addi(5'd21, 5'd21, 12'hfff));
  emit(enc_branch(proc_pkg::f3_beq, 5'd21, 5'd0, 13'd8));
  emit(enc_branch(proc_pkg::f3_beq, 5'd0, 5'd0, 13'(loop_pc - here())));
  emit(enc_csrw(5'd21));
  // parks the core on itself
  emit(enc_branch(proc_pkg::f3_beq, 5'd0, 5'd0, 13'd0));
endtask

// --------------------------------------------------------------------------
// reference model
// --------------------------------------------------------------------------

function automatic proc_pkg::word_t alu_ref(logic [2:0] f3, logic alt,
                                            proc_pkg::word_t a, proc_pkg::word_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

task automatic run_model();
  proc_pkg::word_t regs [32];
  proc_pkg::word_t pc, inst, a, b, next_pc;
  logic            done;
  foreach (regs[i]) regs[i] = '0;
  pc = reset_pc;
  done = 1'b0;
  model_count = 0;
  mngr_used = 0;
  while (!done && model_count < 4000) begin
    inst = fetch_word(pc);
    a = regs[inst[19:15]];
    b = regs[inst[24:20]];
    next_pc = pc + 32'd4;
    case (inst[6:0])
      proc_pkg::opc_op: regs[inst[11:7]] = alu_ref(inst[14:12], inst[30], a, b);
      proc_pkg::opc_op_imm: regs[inst[11:7]] = a + {{20{inst[31]}}, inst[31:20]};
      proc_pkg::opc_branch: begin
        if ((a == b) == (inst[14:12] == proc_pkg::f3_beq)) begin
          next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      proc_pkg::opc_system: begin
        if (inst[14:12] == proc_pkg::f3_csrrs) begin
          assert (mngr_used < n_mngr) else fail_text("program reads more mngr2proc values than drawn");
          regs[inst[11:7]] = mngr_vals[mngr_used];
          mngr_used++;
        end else begin
          exp_vals.push_back(a);
          exp_tags.push_back(section_of(pc));
        end
      end
      default: ;
    endcase
    regs[0] = '0;
    if (next_pc == pc) begin
      done = 1'b1;
    end else begin
      model_count++;
    end
    pc = next_pc;
  end
endtask

// File: dv/proc_tb.sv
`timescale 1ns/1ps
/* testbench for proc_top with an instruction memory of random latency,
   a manager source and sink, and checks against an instruction level model */

module proc_tb;

  localparam proc_pkg::word_t reset_pc = 32'h0000_0200;
  localparam int n_mngr = 32;

  logic            clk, reset;
  logic            imem_req_val, imem_req_rdy, imem_resp_val, imem_resp_rdy, imem_resp_drop;
  proc_pkg::word_t imem_req_addr, imem_resp_data;
  logic            mngr2proc_val, mngr2proc_rdy, proc2mngr_val, proc2mngr_rdy;
  logic            commit_inst;
  proc_pkg::word_t mngr2proc_data, proc2mngr_data;

  integer          seed;
  proc_pkg::word_t mngr_vals [n_mngr];
  // outstanding fetches with the oldest first
  proc_pkg::word_t pend_addr [$];
  int              pend_due [$];
  int              cycle, m_idx, gap, commits, mngr_taken;
  logic            fetched;

  `include "proc_tb_model.svh"

  task automatic fail_value(string test, proc_pkg::word_t expected, proc_pkg::word_t actual);
    $display("FAIL %s: expected %08h actual %08h", test, expected, actual);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic fail_text(string what);
    $display("error: %s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  proc_top #(
    .reset_pc(reset_pc)
  ) i_dut (.*);

  always #50 clk = ~clk;

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    imem_req_rdy = 1'b1;
    imem_resp_val = 1'b0;
    imem_resp_data = '0;
    mngr2proc_val = 1'b0;
    mngr2proc_data = '0;
    proc2mngr_rdy = 1'b0;
    seed = 32'hef1bfcb8;
    cycle = 0;
    m_idx = 0;
    gap = 3;
    commits = 0;
    mngr_taken = 0;
    fetched = 1'b0;
    foreach (mngr_vals[i]) mngr_vals[i] = $random(seed);
    build_program();
    run_model();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // watchdog allows 40 cycles per executed instruction plus slack
    repeat ((model_count + 20) * 40) @(posedge clk);
    fail_text("watchdog expired with proc2mngr values still expected");
  end

  // --------------------------------------------------------------------------
  // input drivers
  // --------------------------------------------------------------------------

  always @(posedge clk) begin : drive_inputs
    int delay;
    cycle++;
    // a drop retires the oldest fetch even if its data is not out yet
    if (imem_resp_drop || (imem_resp_val && imem_resp_rdy)) begin
      assert (pend_addr.size() > 0) else fail_text("response taken with no fetch outstanding");
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
    if (imem_req_val && imem_req_rdy) begin
      if (!fetched) begin
        assert (imem_req_addr == reset_pc)
          else fail_value("first_fetch", reset_pc, imem_req_addr);
        fetched = 1'b1;
      end
      delay = $random(seed) & 3;
      pend_addr.push_back(imem_req_addr);
      pend_due.push_back(cycle + delay);
    end
    if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
      imem_resp_val  <= 1'b1;
      imem_resp_data <= fetch_word(pend_addr[0]);
    end else begin
      imem_resp_val  <= 1'b0;
      imem_resp_data <= '0;
    end
    // every fourth value is followed by a long pause
    if (mngr2proc_val && mngr2proc_rdy) begin
      m_idx++;
      gap = (m_idx % 4 == 2) ? 8 + ($random(seed) & 15) : $random(seed) & 1;
    end
    if (gap > 0) begin
      gap--;
      mngr2proc_val <= 1'b0;
    end else begin
      mngr2proc_val  <= (m_idx < n_mngr);
      mngr2proc_data <= (m_idx < n_mngr) ? mngr_vals[m_idx] : '0;
    end
    // memory turns a request away now and then
    imem_req_rdy  <= ($random(seed) & 7) != 0;
    proc2mngr_rdy <= ($random(seed) & 3) != 0;
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  assert property (@(posedge clk) reset && $past(reset) |->
                   !imem_req_val && !proc2mngr_val && !mngr2proc_rdy && !commit_inst)
    else fail_text("strobe high while reset is asserted");

  assert property (@(posedge clk) $fell(reset) |->
                   !proc2mngr_val && !mngr2proc_rdy && !commit_inst && !imem_resp_drop)
    else fail_text("strobe high in the first cycle after reset");

  // held value may not change or vanish
  assert property (@(posedge clk) disable iff (reset)
                   proc2mngr_val && !proc2mngr_rdy |=> proc2mngr_val && $stable(proc2mngr_data))
    else fail_text("proc2mngr value changed or vanished while held off");

  always @(posedge clk) begin
    if (!reset) begin
      if (commit_inst) begin
        commits++;
      end
      if (mngr2proc_val && mngr2proc_rdy) begin
        mngr_taken++;
      end
      if (proc2mngr_val && proc2mngr_rdy) begin
        assert (exp_vals.size() > 0)
          else fail_text("proc2mngr sent a value the program never writes");
        assert (proc2mngr_data == exp_vals[0])
          else fail_value(exp_tags[0], exp_vals[0], proc2mngr_data);
        void'(exp_vals.pop_front());
        void'(exp_tags.pop_front());
        // last csrw retires right before the parking branch
        if (exp_vals.size() == 0) begin
          if (commits != model_count) begin
            fail_value("commit_count", model_count, commits);
          end else if (mngr_taken != mngr_used) begin
            fail_value("mngr2proc_count", mngr_used, mngr_taken);
          end else begin
            $display("TEST OK");
            $finish;
          end
        end
      end
    end
  end

endmodule

// File: proc_top.f
+incdir+dv
hw/proc_pkg.sv
hw/proc_ctrl.sv
hw/proc_fetch.sv
hw/proc_regfile.sv
hw/proc_decode_dpath.sv
hw/proc_exec_dpath.sv
hw/proc_retire_dpath.sv
hw/proc_top.sv
dv/proc_tb.sv
